// File: hw/viterbi_pkg.sv
package viterbi_pkg;

    // frame geometry.
    localparam int NUM_CHANNELS = 40;
    localparam int ERROR_WIDTH = 8;
    localparam int BRANCH_LENGTH = 2;          // samples per step.
    localparam int NUM_CHUNKS = 5;
    localparam int CHUNK_SIZE = 8;
    localparam int IDX_WIDTH = 6;
    localparam int CHUNK_WIDTH = 3;

    // run termination.
    localparam int ZERO_RUN_LIMIT = 8;

    // trellis model and metrics.
    localparam int ERR_AMP = 16;               // expected residual of a flip.
    localparam int METRIC_WIDTH = 10;
    localparam logic [METRIC_WIDTH-1:0] METRIC_MAX = '1;

    // survivor and result.
    localparam int SURV_DEPTH = 32;
    localparam int STEP_WIDTH = 8;

    localparam int FIFO_DEPTH = 4;

    // Input frame. Sample k sits in samples[k] and is read as a signed value.
    typedef struct packed {
        logic [CHUNK_WIDTH-1:0]                    start_chunk;
        logic [NUM_CHANNELS-1:0]                   flags;
        logic [NUM_CHANNELS-1:0][ERROR_WIDTH-1:0]  samples;
    } frame_entry_t;

    // decision word pushed at run end.
    typedef struct packed {
        logic [SURV_DEPTH-1:0] path;            // newest decision in bit 0.
        logic [STEP_WIDTH-1:0] steps;
    } decision_t;

endpackage

// File: hw/frame_fifo.sv
`timescale 1ns/100ps

module frame_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    payload_t mem [viterbi_pkg::FIFO_DEPTH];

    logic [$clog2(viterbi_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(viterbi_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(viterbi_pkg::FIFO_DEPTH):0]   count;
    logic                                       do_push;
    logic                                       do_pop;

    function automatic logic [$clog2(viterbi_pkg::FIFO_DEPTH)-1:0] next_ptr(
        input logic [$clog2(viterbi_pkg::FIFO_DEPTH)-1:0] ptr
    );
        if (int'(ptr) == viterbi_pkg::FIFO_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (int'(count) == viterbi_pkg::FIFO_DEPTH);
    assign do_push = push && !full;          // push on full is dropped.
    assign do_pop = pop && !empty;
    assign head = mem[rd_ptr];               // fall-through head.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: hw/viterbi_input_controller.sv
`timescale 1ns/100ps

module viterbi_input_controller (
    input  logic                      clk,
    input  logic                      rst_n,
    input  viterbi_pkg::frame_entry_t frame,
    input  logic                      fifo_empty,
    input  logic                      out_full,
    output logic                      pop_n,
    output logic [viterbi_pkg::BRANCH_LENGTH-1:0][viterbi_pkg::ERROR_WIDTH-1:0] trace_vals,
    output logic                      run,
    output logic                      initialize,
    output logic                      path_done
);

    typedef enum logic [2:0] {
        RESET,
        WAIT_FOR_FRAME,
        INITIALIZE,
        RUN,
        GATHER_FRAME,
        DONE
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_d;

    logic [viterbi_pkg::NUM_CHANNELS-1:0][viterbi_pkg::ERROR_WIDTH-1:0] samples_q;
    logic [viterbi_pkg::NUM_CHANNELS-1:0]             flags_q;
    logic [viterbi_pkg::IDX_WIDTH-1:0]                idx;
    logic [viterbi_pkg::IDX_WIDTH-1:0]                idx_d;
    logic [viterbi_pkg::IDX_WIDTH-1:0]                start_idx;
    logic [viterbi_pkg::IDX_WIDTH-1:0]                next_pair_idx;
    logic [$clog2(viterbi_pkg::ZERO_RUN_LIMIT+1)-1:0] zero_cnt;
    logic [$clog2(viterbi_pkg::ZERO_RUN_LIMIT+1)-1:0] zero_cnt_d;
    logic                                             pair_flag;
    logic                                             last_pair;

    // chunks past the frame end fall back to sample 0.
    always_comb begin
        int start_full;
        int step_full;
        start_full = 0;
        if (frame.start_chunk < viterbi_pkg::NUM_CHUNKS) begin
            start_full = int'(frame.start_chunk) * viterbi_pkg::CHUNK_SIZE;
        end
        step_full = int'(idx) + viterbi_pkg::BRANCH_LENGTH;
        start_idx = start_full[viterbi_pkg::IDX_WIDTH-1:0];
        next_pair_idx = step_full[viterbi_pkg::IDX_WIDTH-1:0];
    end

    assign last_pair = (int'(idx) == viterbi_pkg::NUM_CHANNELS - viterbi_pkg::BRANCH_LENGTH);
    assign pair_flag = |flags_q[idx +: viterbi_pkg::BRANCH_LENGTH];

    always_comb begin
        for (int k = 0; k < viterbi_pkg::BRANCH_LENGTH; k++) begin
            trace_vals[k] = samples_q[int'(idx) + k];
        end
    end

    // head is taken in the same cycle it is popped.
    assign pop_n = !(((state == WAIT_FOR_FRAME) || (state == GATHER_FRAME)) && !fifo_empty);
    assign initialize = (state == INITIALIZE);
    assign run = (state == RUN);
    assign path_done = (state == DONE) && !out_full;

    always_comb begin
        state_d = state;
        idx_d = idx;
        zero_cnt_d = zero_cnt;
        case (state)
            RESET: begin
                state_d = WAIT_FOR_FRAME;
                idx_d = '0;
                zero_cnt_d = '0;
            end
            WAIT_FOR_FRAME: begin
                if (!fifo_empty) begin
                    state_d = INITIALIZE;
                    idx_d = start_idx;           // first frame of a run only.
                    zero_cnt_d = '0;
                end
            end
            INITIALIZE, RUN: begin
                zero_cnt_d = pair_flag ? '0 : zero_cnt + 1'b1;
                if (zero_cnt == viterbi_pkg::ZERO_RUN_LIMIT) begin
                    state_d = DONE;              // wins over gather.
                end else if (last_pair) begin
                    state_d = GATHER_FRAME;
                    idx_d = '0;
                end else begin
                    state_d = RUN;
                    idx_d = next_pair_idx;
                end
            end
            GATHER_FRAME: begin
                if (!fifo_empty) begin
                    state_d = RUN;
                    idx_d = '0;                  // later frames start at 0.
                end
            end
            DONE: begin
                if (!out_full) begin
                    state_d = WAIT_FOR_FRAME;
                end
            end
            default: begin
                state_d = RESET;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RESET;
            idx <= '0;
            zero_cnt <= '0;
        end else begin
            state <= state_d;
            idx <= idx_d;
            zero_cnt <= zero_cnt_d;
        end
    end

    // samples and flags reload together on every pop.
    always_ff @(posedge clk) begin
        if (!pop_n) begin
            samples_q <= frame.samples;
            flags_q <= frame.flags;
        end
    end

endmodule

// File: hw/branch_acs_unit.sv
`timescale 1ns/100ps

module branch_acs_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic [viterbi_pkg::BRANCH_LENGTH-1:0][viterbi_pkg::ERROR_WIDTH-1:0] trace_vals,
    input  logic run,
    input  logic initialize,
    output logic [viterbi_pkg::BRANCH_LENGTH-1:0][1:0] dec,
    output logic best_state
);

    logic [1:0][viterbi_pkg::METRIC_WIDTH-1:0] pm_q;
    logic [1:0][viterbi_pkg::METRIC_WIDTH-1:0] pm_d;

    // |sample - ERR_AMP * (cur - prev)|, at most 144.
    function automatic logic [viterbi_pkg::METRIC_WIDTH+1:0] branch_metric(
        input logic signed [viterbi_pkg::ERROR_WIDTH-1:0] sample,
        input int                                         prev,
        input int                                         cur
    );
        int diff;
        diff = int'(sample) - viterbi_pkg::ERR_AMP * (cur - prev);
        if (diff < 0) begin
            diff = -diff;
        end
        return diff[viterbi_pkg::METRIC_WIDTH+1:0];
    endfunction

    // Two guard bits cover the growth of two stages before normalization.
    always_comb begin
        logic [1:0][viterbi_pkg::METRIC_WIDTH+1:0] acc;
        logic [1:0][viterbi_pkg::METRIC_WIDTH+1:0] nxt;
        logic [viterbi_pkg::METRIC_WIDTH+1:0]      sum0;
        logic [viterbi_pkg::METRIC_WIDTH+1:0]      sum1;
        logic [viterbi_pkg::METRIC_WIDTH+1:0]      low;
        logic [viterbi_pkg::METRIC_WIDTH+1:0]      norm;
        acc[0] = initialize ? '0 : {2'b00, pm_q[0]};
        acc[1] = initialize ? {2'b00, viterbi_pkg::METRIC_MAX} : {2'b00, pm_q[1]};
        for (int s = 0; s < viterbi_pkg::BRANCH_LENGTH; s++) begin
            for (int c = 0; c < 2; c++) begin
                sum0 = acc[0] + branch_metric($signed(trace_vals[s]), 0, c);
                sum1 = acc[1] + branch_metric($signed(trace_vals[s]), 1, c);
                dec[s][c] = (sum1 < sum0);       // tie keeps state 0.
                nxt[c] = dec[s][c] ? sum1 : sum0;
            end
            acc = nxt;
        end
        low = (acc[1] < acc[0]) ? acc[1] : acc[0];
        for (int c = 0; c < 2; c++) begin
            norm = acc[c] - low;
            if (norm > {2'b00, viterbi_pkg::METRIC_MAX}) begin
                pm_d[c] = viterbi_pkg::METRIC_MAX;
            end else begin
                pm_d[c] = norm[viterbi_pkg::METRIC_WIDTH-1:0];
            end
        end
        best_state = (pm_d[0] != '0);           // state 0 on a tie.
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pm_q <= '0;
        end else if (run || initialize) begin
            pm_q <= pm_d;
        end
    end

endmodule

// File: hw/survivor_path.sv
`timescale 1ns/100ps

module survivor_path (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       run,
    input  logic                                       initialize,
    input  logic [viterbi_pkg::BRANCH_LENGTH-1:0][1:0] dec,
    input  logic                                       best_state,
    output viterbi_pkg::decision_t                     decision
);

    logic [1:0][viterbi_pkg::SURV_DEPTH-1:0] word_q;
    logic [1:0][viterbi_pkg::SURV_DEPTH-1:0] word_d;
    logic                                    best_q;
    logic [viterbi_pkg::STEP_WIDTH-1:0]      steps_q;

    // register exchange, one shift per stage.
    always_comb begin
        logic [1:0][viterbi_pkg::SURV_DEPTH-1:0] base;
        logic [1:0][viterbi_pkg::SURV_DEPTH-1:0] nxt;
        base = initialize ? '0 : word_q;
        for (int s = 0; s < viterbi_pkg::BRANCH_LENGTH; s++) begin
            for (int c = 0; c < 2; c++) begin
                nxt[c] = {base[dec[s][c]][viterbi_pkg::SURV_DEPTH-2:0], c[0]};
            end
            base = nxt;
        end
        word_d = base;
    end

    always_ff @(posedge clk) begin
        if (run || initialize) begin
            word_q <= word_d;
            best_q <= best_state;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            steps_q <= '0;
        end else if (initialize) begin
            steps_q <= {{(viterbi_pkg::STEP_WIDTH-1){1'b0}}, 1'b1};
        end else if (run && (steps_q != '1)) begin
            steps_q <= steps_q + 1'b1;           // saturates at 255.
        end
    end

    always_comb begin
        decision.path = word_q[best_q];
        decision.steps = steps_q;
    end

endmodule

// File: hw/viterbi_top.sv
`timescale 1ns/100ps

module viterbi_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_push,
    input  viterbi_pkg::frame_entry_t in_data,
    output logic                      in_full,
    input  logic                      out_pop,
    output viterbi_pkg::decision_t    out_data,
    output logic                      out_valid
);

    viterbi_pkg::frame_entry_t in_head;
    viterbi_pkg::decision_t    decision;
    logic                      in_empty;
    logic                      pop_n;
    logic                      out_full;
    logic                      out_empty;
    logic                      run;
    logic                      initialize;
    logic                      path_done;
    logic                      best_state;
    logic [viterbi_pkg::BRANCH_LENGTH-1:0][viterbi_pkg::ERROR_WIDTH-1:0] trace_vals;
    logic [viterbi_pkg::BRANCH_LENGTH-1:0][1:0] dec;

    frame_fifo #(.payload_t(viterbi_pkg::frame_entry_t)) in_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_push),
        .push_data (in_data),
        .pop       (!pop_n),
        .head      (in_head),
        .empty     (in_empty),
        .full      (in_full)
    );

    viterbi_input_controller u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame      (in_head),
        .fifo_empty (in_empty),
        .out_full   (out_full),
        .pop_n      (pop_n),
        .trace_vals (trace_vals),
        .run        (run),
        .initialize (initialize),
        .path_done  (path_done)
    );

    branch_acs_unit u_acs (
        .clk        (clk),
        .rst_n      (rst_n),
        .trace_vals (trace_vals),
        .run        (run),
        .initialize (initialize),
        .dec        (dec),
        .best_state (best_state)
    );

    survivor_path u_surv (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .initialize (initialize),
        .dec        (dec),
        .best_state (best_state),
        .decision   (decision)
    );

    frame_fifo #(.payload_t(viterbi_pkg::decision_t)) out_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (path_done),
        .push_data (decision),
        .pop       (out_pop),
        .head      (out_data),
        .empty     (out_empty),
        .full      (out_full)
    );

    assign out_valid = !out_empty;

endmodule

// File: tb/viterbi_assert.sv
`timescale 1ns/100ps

module viterbi_assert (
    input logic clk,
    input logic rst_n,
    input logic in_push,
    input logic in_full,
    input logic in_empty,
    input logic pop_n,
    input logic run,
    input logic initialize,
    input logic path_done,
    input logic out_full
);

    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) !pop_n |-> !in_empty)
        else $error("input FIFO popped while empty");

    push_not_full: assert property (@(posedge clk) disable iff (!rst_n) in_push |-> !in_full)
        else $error("input FIFO pushed while full");

    one_step_kind: assert property (@(posedge clk) disable iff (!rst_n) !(run && initialize))
        else $error("run and initialize high together");

    done_not_full: assert property (@(posedge clk) disable iff (!rst_n) path_done |-> !out_full)
        else $error("path_done fired while output FIFO full");

endmodule

// File: tb/viterbi_tb.sv
`timescale 1ns/100ps

module viterbi_tb;

    localparam int MAX_FRAMES = 3;
    localparam int TOTAL_FRAMES = 48;                  // 16 runs of at most 3 frames.
    localparam int LIMIT_CYCLES = TOTAL_FRAMES * 60 + 400;

    logic                      clk;
    logic                      rst_n;
    logic                      in_push;
    viterbi_pkg::frame_entry_t in_data;
    logic                      in_full;
    logic                      out_pop;
    viterbi_pkg::decision_t    out_data;
    logic                      out_valid;

    logic signed [viterbi_pkg::ERROR_WIDTH-1:0] smp [MAX_FRAMES][viterbi_pkg::NUM_CHANNELS];
    logic                   flg [MAX_FRAMES][viterbi_pkg::NUM_CHANNELS];
    viterbi_pkg::decision_t exp_q [$];
    logic [31:0]            rng_state;
    logic                   pop_enable;
    int                     errors;
    int                     checks;
    int                     tests_run;

    viterbi_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_push   (in_push),
        .in_data   (in_data),
        .in_full   (in_full),
        .out_pop   (out_pop),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

    bind viterbi_top viterbi_assert u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_push    (in_push),
        .in_full    (in_full),
        .in_empty   (in_empty),
        .pop_n      (pop_n),
        .run        (run),
        .initialize (initialize),
        .path_done  (path_done),
        .out_full   (out_full)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_random() % 32'(n));
    endfunction

    function automatic int abs_int(input int x);
        return (x < 0) ? -x : x;
    endfunction

    // mode 0 noisy levels, 1 dipoles and ties, 2 constant offset.
    function automatic logic signed [7:0] gen_sample(input int mode);
        int v;
        if (mode == 0) begin
            v = (rand_below(3) - 1) * viterbi_pkg::ERR_AMP + rand_below(7) - 3;
        end else if (mode == 1) begin
            case (rand_below(10))
                0:       v = viterbi_pkg::ERR_AMP;
                1:       v = -viterbi_pkg::ERR_AMP;
                2:       v = viterbi_pkg::ERR_AMP / 2;   // equal branch sums.
                3:       v = -viterbi_pkg::ERR_AMP / 2;
                default: v = 0;
            endcase
        end else begin
            v = 120 + rand_below(8);
        end
        return v[7:0];
    endfunction

    // last frame keeps its flags below sample 16, so every run ends.
    task automatic make_frames(input int mode, input int span, input bit dense);
        int lim;
        for (int f = 0; f < MAX_FRAMES; f++) begin
            lim = (f == MAX_FRAMES - 1 && span > 16) ? 16 : span;
            for (int k = 0; k < viterbi_pkg::NUM_CHANNELS; k++) begin
                smp[f][k] = gen_sample(mode);
                if (k >= lim) begin
                    flg[f][k] = 1'b0;
                end else if (dense) begin
                    flg[f][k] = (k % 6 == 0);
                end else begin
                    flg[f][k] = (rand_below(4) == 0);
                end
            end
        end
    endtask

    // steps, termination and trellis replayed in integers.
    function automatic viterbi_pkg::decision_t ref_detect(input int start, output int used);
        viterbi_pkg::decision_t res;
        int          pm [2];
        int          nxt [2];
        int          sum0;
        int          sum1;
        int          d;
        int          f;
        int          idx;
        int          zc;
        int          steps;
        int          best;
        bit          stop;
        bit          finished;
        logic [31:0] w [2];
        logic [31:0] nw [2];
        pm[0] = 0;
        pm[1] = int'(viterbi_pkg::METRIC_MAX);
        w[0] = '0;
        w[1] = '0;
        f = 0;
        idx = start;
        zc = 0;
        steps = 0;
        best = 0;
        finished = 1'b0;
        while (!finished && f < MAX_FRAMES) begin
            for (int s = 0; s < viterbi_pkg::BRANCH_LENGTH; s++) begin
                for (int c = 0; c < 2; c++) begin
                    sum0 = pm[0] + abs_int(int'(smp[f][idx+s]) - viterbi_pkg::ERR_AMP * c);
                    sum1 = pm[1] + abs_int(int'(smp[f][idx+s]) - viterbi_pkg::ERR_AMP * (c - 1));
                    d = (sum1 < sum0) ? 1 : 0;     // tie goes to state 0.
                    nxt[c] = (d == 1) ? sum1 : sum0;
                    nw[c] = {w[d][viterbi_pkg::SURV_DEPTH-2:0], c[0]};
                end
                pm = nxt;
                w = nw;
            end
            sum0 = (pm[1] < pm[0]) ? pm[1] : pm[0];
            for (int c = 0; c < 2; c++) begin
                pm[c] = pm[c] - sum0;
                if (pm[c] > int'(viterbi_pkg::METRIC_MAX)) begin
                    pm[c] = int'(viterbi_pkg::METRIC_MAX);
                end
            end
            best = (pm[0] != 0) ? 1 : 0;
            steps = (steps < 255) ? steps + 1 : 255;
            stop = (zc == viterbi_pkg::ZERO_RUN_LIMIT);
            zc = (flg[f][idx] || flg[f][idx+1]) ? 0 : zc + 1;
            if (stop) begin
                finished = 1'b1;
            end else if (idx == viterbi_pkg::NUM_CHANNELS - viterbi_pkg::BRANCH_LENGTH) begin
                f++;
                idx = 0;
            end else begin
                idx += viterbi_pkg::BRANCH_LENGTH;
            end
        end
        used = f + 1;
        res.path = w[best];
        res.steps = steps[7:0];
        return res;
    endfunction

    task automatic push_run(input int start, input int nframes, input int gap);
        viterbi_pkg::frame_entry_t fr;
        for (int f = 0; f < nframes; f++) begin
            for (int k = 0; k < viterbi_pkg::NUM_CHANNELS; k++) begin
                fr.samples[k] = smp[f][k];
                fr.flags[k] = flg[f][k];
            end
            fr.start_chunk = 3'((f == 0) ? start : rand_below(viterbi_pkg::NUM_CHUNKS));
            if (f > 0) begin
                repeat (gap) @(posedge clk);
            end
            @(posedge clk);
            #1;
            while (in_full) begin
                @(posedge clk);
                #1;
            end
            in_push = 1'b1;
            in_data = fr;
            @(posedge clk);
            #1;
            in_push = 1'b0;
        end
    endtask

    task automatic run_case(input int chunk, input int mode, input int span, input bit dense,
                            input int gap);
        int used;
        make_frames(mode, span, dense);
        exp_q.push_back(ref_detect(chunk * viterbi_pkg::CHUNK_SIZE, used));
        push_run(chunk, used, gap);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] expd);
        checks++;
        if (got !== expd) begin
            errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, expd);
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, (errors == errs_before) ? "pass" : "FAIL");
    endtask

    // compare process, pops one decision per look.
    initial begin
        viterbi_pkg::decision_t expd;
        out_pop = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_pop = 1'b0;
            if (rst_n && out_valid && pop_enable) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected decision at %0t with nothing left to compare", $time);
                end else begin
                    expd = exp_q.pop_front();
                    check("out_data.path", 64'(out_data.path), 64'(expd.path));
                    check("out_data.steps", 64'(out_data.steps), 64'(expd.steps));
                end
                out_pop = 1'b1;
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", LIMIT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int errs;
        rng_state = 32'h94ff;
        errors = 0;
        checks = 0;
        tests_run = 0;
        pop_enable = 1'b1;
        rst_n = 1'b0;
        in_push = 1'b0;
        in_data = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        errs = errors;
        check("out_valid", 64'(out_valid), 64'(1'b0));  // both FIFOs empty.
        check("in_full", 64'(in_full), 64'(1'b0));
        finish_test("outputs after reset", errs);

        errs = errors;
        run_case(0, 0, 0, 1'b0, 0);                    // nine steps.
        drain();
        finish_test("no flags from chunk 0", errs);

        errs = errors;
        for (int i = 0; i < 3; i++) begin
            run_case(1 + rand_below(4), 0, rand_below(41), 1'b0, 0);
        end
        drain();
        finish_test("non-zero start chunk", errs);

        errs = errors;
        for (int i = 0; i < 2; i++) begin
            run_case(0, 0, 40, 1'b1, 30);              // late frames, waits in gather.
        end
        drain();
        finish_test("gather with late frames", errs);

        errs = errors;
        for (int i = 0; i < 3; i++) begin
            run_case(rand_below(5), 1, rand_below(25), 1'b0, 0);
        end
        drain();
        finish_test("dipoles and ties", errs);

        errs = errors;
        pop_enable = 1'b0;
        for (int i = 0; i < 5; i++) begin
            run_case(rand_below(5), 0, 0, 1'b0, 0);
        end
        while (!dut.out_full) @(posedge clk);
        repeat (20) @(posedge clk);                    // fifth run held in done.
        check("out_valid", 64'(out_valid), 64'(1'b1));
        pop_enable = 1'b1;
        drain();
        finish_test("output back-pressure", errs);

        errs = errors;
        run_case(0, 2, 40, 1'b1, 0);
        run_case(rand_below(5), 2, 40, 1'b1, 0);
        drain();
        finish_test("long runs with offset", errs);

        repeat (4) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim.f
hw/viterbi_pkg.sv
hw/frame_fifo.sv
hw/viterbi_input_controller.sv
hw/branch_acs_unit.sv
hw/survivor_path.sv
hw/viterbi_top.sv
tb/viterbi_assert.sv
tb/viterbi_tb.sv

// File: Makefile
TOP := viterbi_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

obj_dir/V$(TOP): sim.f hw/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log
